// File: Makefile
TOP := csr_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f csr_unit.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	verilator --lint-only --timing --top-module csr_unit -f csr_unit.f

clean:
	rm -rf obj_dir

// File: bench/clk_gen.sv
`default_nettype none

module clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge so the first active edge is clean
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb;

    localparam logic [31:0] HART_ID     = 32'h0000_0005;
    localparam logic [31:0] TRAP_VECTOR = 32'h0000_0100;
    localparam logic [31:0] MEPC_RESET  = 32'h0001_0000;
    localparam logic [31:0] IRQ_BITS    = 32'h0000_0888;
    localparam int          WAIT_LIMIT  = 20;

    logic               clk;
    logic               rst_n;
    csr_pkg::csr_req_t  csr_req;
    csr_pkg::trap_req_t trap_req;
    logic               mret;
    logic               rd_valid;
    logic [31:0]        rd_data;
    logic [31:0]        trap_vector;
    logic [31:0]        mepc_out;
    csr_pkg::priv_t     priv_mode;
    logic               is_ecall;

    // Reference model state, updated on the rising edge
    csr_pkg::priv_t mdl_mode;
    logic [1:0]     mdl_mpp;
    logic           mdl_mpie;
    logic           mdl_st_mie;
    logic [31:0]    mdl_mie;
    logic [31:0]    mdl_mip;
    logic [31:0]    mdl_mscratch;
    logic [31:0]    mdl_mepc;
    logic [31:0]    mdl_mcause;
    logic [31:0]    mdl_mtval;
    logic           exp_valid;
    logic [31:0]    exp_data;

    int check_errors   = 0;
    int timeout_errors = 0;
    int reach_errors   = 0;
    int responses      = 0;
    int ecall_cycles   = 0;
    int user_cycles    = 0;
    int super_cycles   = 0;

    // Read-only and unknown addresses
    logic [11:0] ro_addrs [8] = '{
        csr_pkg::addr_mvendorid, csr_pkg::addr_marchid, csr_pkg::addr_mimpid,
        csr_pkg::addr_mhartid, csr_pkg::addr_misa, csr_pkg::addr_mtvec,
        csr_pkg::addr_mcounteren, 12'h7c0
    };
    logic [11:0] rw_addrs [7] = '{
        csr_pkg::addr_mstatus, csr_pkg::addr_mie, csr_pkg::addr_mip,
        csr_pkg::addr_mscratch, csr_pkg::addr_mepc, csr_pkg::addr_mcause,
        csr_pkg::addr_mtval
    };

    clk_gen #(.PERIOD(40), .RESET_CYCLES(10)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    csr_unit #(
        .HART_ID     (HART_ID),
        .TRAP_VECTOR (TRAP_VECTOR),
        .MEPC_RESET  (MEPC_RESET)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_req     (csr_req),
        .trap_req    (trap_req),
        .mret        (mret),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .trap_vector (trap_vector),
        .mepc_out    (mepc_out),
        .priv_mode   (priv_mode),
        .is_ecall    (is_ecall)
    );

    function automatic logic [31:0] ecall_cause(input csr_pkg::priv_t mode);
        case (mode)
            csr_pkg::priv_u: return 32'd8;
            csr_pkg::priv_s: return 32'd9;
            default:         return 32'd11;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            csr_pkg::addr_mhartid:  return HART_ID;
            csr_pkg::addr_misa:     return 32'h4000_1100;
            csr_pkg::addr_mtvec:    return TRAP_VECTOR;
            csr_pkg::addr_mstatus:
                return {19'd0, mdl_mpp, 3'd0, mdl_mpie, 3'd0, mdl_st_mie, 3'd0};
            csr_pkg::addr_mie:      return mdl_mie;
            csr_pkg::addr_mip:      return mdl_mip;
            csr_pkg::addr_mscratch: return mdl_mscratch;
            csr_pkg::addr_mepc:     return mdl_mepc;
            csr_pkg::addr_mcause:   return mdl_mcause;
            csr_pkg::addr_mtval:    return mdl_mtval;
            default:                return 32'd0;
        endcase
    endfunction

    always @(posedge clk) begin
        logic [31:0] old_val;
        logic [31:0] new_val;
        logic        wr;
        if (!rst_n) begin
            mdl_mode     = csr_pkg::priv_m;
            mdl_mpp      = 2'b00;
            mdl_mpie     = 1'b0;
            mdl_st_mie   = 1'b0;
            mdl_mie      = '0;
            mdl_mip      = '0;
            mdl_mscratch = '0;
            mdl_mepc     = MEPC_RESET;
            mdl_mcause   = '0;
            mdl_mtval    = '0;
            exp_valid    = 1'b0;
        end else begin
            old_val   = model_read(csr_req.addr);
            exp_valid = csr_req.valid;
            if (csr_req.valid) begin
                exp_data = old_val;
            end
            case (csr_req.op)
                csr_pkg::csr_rw: new_val = csr_req.operand;
                csr_pkg::csr_rs: new_val = old_val | csr_req.operand;
                default:         new_val = old_val & ~csr_req.operand;
            endcase
            wr = csr_req.valid && (csr_req.op == csr_pkg::csr_rw || csr_req.operand != 0);
            if (wr && csr_req.addr == csr_pkg::addr_mscratch) mdl_mscratch = new_val;
            if (wr && csr_req.addr == csr_pkg::addr_mie) mdl_mie = new_val & IRQ_BITS;
            if (wr && csr_req.addr == csr_pkg::addr_mip) mdl_mip = new_val & IRQ_BITS;
            if (trap_req.valid) begin
                mdl_mepc   = {trap_req.pc[31:2], 2'b00};
                mdl_mtval  = trap_req.tval;
                mdl_mcause = (trap_req.cause == csr_pkg::exc_ecall) ?
                             ecall_cause(mdl_mode) : 32'd0;
                mdl_mpie   = mdl_st_mie;
                mdl_st_mie = 1'b0;
                mdl_mpp    = mdl_mode;
                mdl_mode   = csr_pkg::priv_m;
            end else begin
                if (mret) begin
                    mdl_mode   = csr_pkg::priv_t'(mdl_mpp);
                    mdl_st_mie = mdl_mpie;
                    mdl_mpie   = 1'b1;
                    mdl_mpp    = 2'b00;
                end else if (wr && csr_req.addr == csr_pkg::addr_mstatus) begin
                    // Reserved mpp encoding lands as U
                    mdl_mpp    = (new_val[12:11] == 2'b10) ? 2'b00 : new_val[12:11];
                    mdl_mpie   = new_val[7];
                    mdl_st_mie = new_val[3];
                end
                if (wr && csr_req.addr == csr_pkg::addr_mepc) mdl_mepc = {new_val[31:2], 2'b00};
                if (wr && csr_req.addr == csr_pkg::addr_mcause) mdl_mcause = new_val;
                if (wr && csr_req.addr == csr_pkg::addr_mtval) mdl_mtval = new_val;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        check_errors++;
        $display("CHECK FAILED %s: got %h expected %h", name, got, expected);
    endtask

    // Outputs settle after the rising edge, so sample them at the falling one
    valid_ok: assert property (@(negedge clk) disable iff (!rst_n) rd_valid == exp_valid)
        else report_mismatch("rd_valid", 32'(rd_valid), 32'(exp_valid));
    data_ok: assert property (@(negedge clk) disable iff (!rst_n)
        rd_valid |-> rd_data == exp_data)
        else report_mismatch("rd_data", rd_data, exp_data);
    mode_ok: assert property (@(negedge clk) disable iff (!rst_n) priv_mode == mdl_mode)
        else report_mismatch("priv_mode", 32'(priv_mode), 32'(mdl_mode));
    mepc_ok: assert property (@(negedge clk) disable iff (!rst_n) mepc_out == mdl_mepc)
        else report_mismatch("mepc_out", mepc_out, mdl_mepc);
    ecall_ok: assert property (@(negedge clk) disable iff (!rst_n)
        is_ecall == (mdl_mcause == 32'd11))
        else report_mismatch("is_ecall", 32'(is_ecall), 32'(mdl_mcause == 32'd11));
    vector_ok: assert property (@(negedge clk) disable iff (!rst_n) trap_vector == TRAP_VECTOR)
        else report_mismatch("trap_vector", trap_vector, TRAP_VECTOR);

    always @(negedge clk) begin
        if (rst_n) begin
            if (rd_valid) responses++;
            if (is_ecall) ecall_cycles++;
            if (priv_mode == csr_pkg::priv_u) user_cycles++;
            if (priv_mode == csr_pkg::priv_s) super_cycles++;
        end
    end

    task automatic finish_run();
        $display("Errors: %0d check, %0d timeout, %0d coverage",
                 check_errors, timeout_errors, reach_errors);
        if (check_errors + timeout_errors + reach_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic drive_csr(input csr_pkg::csr_op_t op, input logic [11:0] addr,
                             input logic [31:0] operand);
        @(negedge clk);
        csr_req.valid   = 1'b1;
        csr_req.op      = op;
        csr_req.addr    = addr;
        csr_req.operand = operand;
        trap_req        = '0;
        mret            = 1'b0;
    endtask

    task automatic drive_trap(input csr_pkg::exc_cause_t cause, input logic write_mepc,
                              input logic [31:0] mepc_data);
        @(negedge clk);
        trap_req.valid = 1'b1;
        trap_req.cause = cause;
        trap_req.pc    = $urandom();
        trap_req.tval  = $urandom();
        csr_req        = '0;
        mret           = 1'b0;
        // Same-cycle mepc write, which the trap overrides
        if (write_mepc) begin
            csr_req.valid   = 1'b1;
            csr_req.op      = csr_pkg::csr_rw;
            csr_req.addr    = csr_pkg::addr_mepc;
            csr_req.operand = mepc_data;
        end
    endtask

    task automatic drive_mret();
        @(negedge clk);
        csr_req  = '0;
        trap_req = '0;
        mret     = 1'b1;
    endtask

    task automatic settle();
        int n;
        @(negedge clk);
        csr_req  = '0;
        trap_req = '0;
        mret     = 1'b0;
        n = 0;
        while (rd_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rd_valid) begin
            $display("Timeout: rd_valid did not drop after the last request");
            timeout_errors++;
            finish_run();
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeout_errors++;
            finish_run();
        end
    endtask

    task automatic rmw_random();
        csr_pkg::csr_op_t op;
        logic [11:0]      addr;
        logic [31:0]      operand;
        case ($urandom_range(0, 2))
            0:       op = csr_pkg::csr_rw;
            1:       op = csr_pkg::csr_rs;
            default: op = csr_pkg::csr_rc;
        endcase
        case ($urandom_range(0, 2))
            0:       addr = csr_pkg::addr_mscratch;
            1:       addr = csr_pkg::addr_mie;
            default: addr = csr_pkg::addr_mip;
        endcase
        // Zero operand now and then, so set and clear become pure reads
        operand = ($urandom_range(0, 7) == 0) ? 32'd0 : $urandom();
        drive_csr(op, addr, operand);
    endtask

    initial begin
        csr_req  = '0;
        trap_req = '0;
        mret     = 1'b0;
        void'($urandom(4841));
        wait_reset();

        foreach (ro_addrs[i]) drive_csr(csr_pkg::csr_rs, ro_addrs[i], 32'd0);
        foreach (rw_addrs[i]) drive_csr(csr_pkg::csr_rs, rw_addrs[i], 32'd0);
        foreach (ro_addrs[i]) begin
            drive_csr(csr_pkg::csr_rw, ro_addrs[i], $urandom());
            drive_csr(csr_pkg::csr_rs, ro_addrs[i], 32'd0);
        end
        settle();

        for (int n = 0; n < 64; n++) begin
            rmw_random();
            if (n % 8 == 7) settle();
        end

        // mstatus masking, then mpp = 2 on purpose
        for (int n = 0; n < 16; n++) begin
            drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mstatus, $urandom());
            drive_csr(csr_pkg::csr_rs, csr_pkg::addr_mstatus, 32'd0);
        end
        drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mstatus, 32'h0000_1000);
        drive_csr(csr_pkg::csr_rs, csr_pkg::addr_mstatus, 32'd0);
        settle();

        // U-mode ecall, then a misaligned fetch racing an mepc write
        drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mstatus, 32'h0000_0088);
        drive_mret();
        drive_trap(csr_pkg::exc_ecall, 1'b0, 32'd0);
        foreach (rw_addrs[i]) drive_csr(csr_pkg::csr_rs, rw_addrs[i], 32'd0);
        drive_mret();
        drive_trap(csr_pkg::exc_i_misaligned, 1'b1, $urandom());
        foreach (rw_addrs[i]) drive_csr(csr_pkg::csr_rs, rw_addrs[i], 32'd0);

        // S-mode ecall and return
        drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mstatus, 32'h0000_0800);
        drive_mret();
        drive_trap(csr_pkg::exc_ecall, 1'b0, 32'd0);
        drive_csr(csr_pkg::csr_rs, csr_pkg::addr_mcause, 32'd0);
        drive_mret();

        // Back to M-mode for an M-mode ecall
        drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mstatus, 32'h0000_1808);
        drive_mret();
        drive_trap(csr_pkg::exc_ecall, 1'b0, 32'd0);
        drive_csr(csr_pkg::csr_rs, csr_pkg::addr_mstatus, 32'd0);
        settle();

        drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mcause, 32'd0);
        drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mcause, 32'd11);
        drive_csr(csr_pkg::csr_rs, csr_pkg::addr_mcause, 32'd0);
        drive_csr(csr_pkg::csr_rc, csr_pkg::addr_mcause, 32'd1);
        settle();

        // Direct mepc and mtval writes, mepc drops its low bits
        drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mepc, $urandom());
        drive_csr(csr_pkg::csr_rw, csr_pkg::addr_mtval, $urandom());
        drive_csr(csr_pkg::csr_rs, csr_pkg::addr_mepc, 32'd0);
        drive_csr(csr_pkg::csr_rs, csr_pkg::addr_mtval, 32'd0);
        settle();

        if (responses == 0 || ecall_cycles == 0 || user_cycles == 0 || super_cycles == 0) begin
            $display("Coverage gap: responses, ecall, U-mode or S-mode never observed");
            reach_errors++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: csr_unit.f
verilog/csr_pkg.sv
verilog/mstatus_reg.sv
verilog/int_enable_regs.sv
verilog/trap_regs.sv
verilog/csrs.sv
verilog/csr_op_unit.sv
verilog/csr_unit.sv
bench/clk_gen.sv
bench/csr_unit_tb.sv

// File: verilog/csr_op_unit.sv
`default_nettype none

module csr_op_unit (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire csr_pkg::csr_req_t  csr_req,
    input  wire logic [31:0]        rd_value,
    output logic [11:0]             rd_addr,
    output csr_pkg::csr_wr_t        csr_wr,
    output logic                    rd_valid,
    output logic [31:0]             rd_data
);

    logic [31:0] new_value;
    logic        do_write;
    logic        rd_valid_q;
    logic [31:0] rd_data_q;

    assign rd_addr = csr_req.addr;

    always_comb begin
        case (csr_req.op)
            csr_pkg::csr_rw: new_value = csr_req.operand;
            csr_pkg::csr_rs: new_value = rd_value | csr_req.operand;
            csr_pkg::csr_rc: new_value = rd_value & ~csr_req.operand;
            default:         new_value = rd_value;
        endcase
    end

    // Set and clear with a zero operand are pure reads
    assign do_write = csr_req.valid &&
                      (csr_req.op == csr_pkg::csr_rw || csr_req.operand != '0);

    assign csr_wr.en   = do_write;
    assign csr_wr.addr = csr_req.addr;
    assign csr_wr.data = new_value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= csr_req.valid;
        end
    end

    // Old value, captured before the write lands
    always_ff @(posedge clk) begin
        if (csr_req.valid) begin
            rd_data_q <= rd_value;
        end
    end

    assign rd_valid = rd_valid_q;
    assign rd_data  = rd_data_q;

    legal_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        csr_req.valid |-> csr_req.op inside {csr_pkg::csr_rw, csr_pkg::csr_rs, csr_pkg::csr_rc}
    ) else $error("illegal CSR op %0d", csr_req.op);

endmodule

`default_nettype wire

// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Machine information registers
    localparam logic [11:0] addr_mvendorid  = 12'hf11;
    localparam logic [11:0] addr_marchid    = 12'hf12;
    localparam logic [11:0] addr_mimpid     = 12'hf13;
    localparam logic [11:0] addr_mhartid    = 12'hf14;

    // Machine trap setup
    localparam logic [11:0] addr_mstatus    = 12'h300;
    localparam logic [11:0] addr_misa       = 12'h301;
    localparam logic [11:0] addr_mie        = 12'h304;
    localparam logic [11:0] addr_mtvec      = 12'h305;
    localparam logic [11:0] addr_mcounteren = 12'h306;

    // Machine trap handling
    localparam logic [11:0] addr_mscratch   = 12'h340;
    localparam logic [11:0] addr_mepc       = 12'h341;
    localparam logic [11:0] addr_mcause     = 12'h342;
    localparam logic [11:0] addr_mtval      = 12'h343;
    localparam logic [11:0] addr_mip        = 12'h344;

    typedef enum logic [1:0] {
        priv_u = 2'd0,
        priv_s = 2'd1,
        priv_m = 2'd3
    } priv_t;

    // Trap kind as reported by the pipeline
    typedef enum logic [1:0] {
        exc_none         = 2'd0,
        exc_i_misaligned = 2'd1,
        exc_ecall        = 2'd3
    } exc_cause_t;

    localparam logic [31:0] mcause_i_misaligned = 32'd0;
    localparam logic [31:0] mcause_ecall_u      = 32'd8;
    localparam logic [31:0] mcause_ecall_s      = 32'd9;
    localparam logic [31:0] mcause_ecall_m      = 32'd11;

    // Matches the low bits of funct3
    typedef enum logic [1:0] {
        csr_rw = 2'd1,
        csr_rs = 2'd2,
        csr_rc = 2'd3
    } csr_op_t;

    typedef struct packed {
        logic        valid;
        csr_op_t     op;
        logic [11:0] addr;
        logic [31:0] operand;
    } csr_req_t;

    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic        valid;
        exc_cause_t  cause;
        logic [31:0] pc;
        logic [31:0] tval;
    } trap_req_t;

    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [31:0]     raw;
        mstatus_fields_t f;
    } mstatus_u;

    localparam logic [31:0] mstatus_wmask = 32'h0000_1888;
    localparam logic [31:0] mie_wmask     = 32'h0000_0888;
    localparam logic [31:0] mip_wmask     = 32'h0000_0888;

    // MXL = 1, extensions I and M
    localparam logic [31:0] misa_value    = 32'h4000_1100;

endpackage

`default_nettype wire

// File: verilog/csr_unit.sv
`default_nettype none

module csr_unit #(
    parameter logic [31:0] HART_ID     = 32'h0000_0000,
    parameter logic [31:0] TRAP_VECTOR = 32'h0000_0100,
    parameter logic [31:0] MEPC_RESET  = 32'h0001_0000
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire csr_pkg::csr_req_t   csr_req,
    input  wire csr_pkg::trap_req_t  trap_req,
    input  wire logic                mret,
    output logic                     rd_valid,
    output logic [31:0]              rd_data,
    output logic [31:0]              trap_vector,
    output logic [31:0]              mepc_out,
    output csr_pkg::priv_t           priv_mode,
    output logic                     is_ecall
);

    logic [11:0]      rd_addr;
    logic [31:0]      rd_value;
    csr_pkg::csr_wr_t csr_wr;

    csr_op_unit u_csr_op_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_req  (csr_req),
        .rd_value (rd_value),
        .rd_addr  (rd_addr),
        .csr_wr   (csr_wr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    csrs #(
        .HART_ID     (HART_ID),
        .TRAP_VECTOR (TRAP_VECTOR),
        .MEPC_RESET  (MEPC_RESET)
    ) u_csrs (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_addr     (rd_addr),
        .csr_wr      (csr_wr),
        .trap_req    (trap_req),
        .mret        (mret),
        .rd_value    (rd_value),
        .trap_vector (trap_vector),
        .mepc_out    (mepc_out),
        .priv_mode   (priv_mode),
        .is_ecall    (is_ecall)
    );

endmodule

`default_nettype wire

// File: verilog/csrs.sv
`default_nettype none

module csrs #(
    parameter logic [31:0] HART_ID     = 32'h0000_0000,
    parameter logic [31:0] TRAP_VECTOR = 32'h0000_0100,
    parameter logic [31:0] MEPC_RESET  = 32'h0001_0000
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [11:0]         rd_addr,
    input  wire csr_pkg::csr_wr_t    csr_wr,
    input  wire csr_pkg::trap_req_t  trap_req,
    input  wire logic                mret,
    output logic [31:0]              rd_value,
    output logic [31:0]              trap_vector,
    output logic [31:0]              mepc_out,
    output csr_pkg::priv_t           priv_mode,
    output logic                     is_ecall
);

    logic        wr_mstatus;
    logic        wr_mie;
    logic        wr_mip;
    logic        wr_mscratch;
    logic        wr_mepc;
    logic        wr_mcause;
    logic        wr_mtval;

    logic [31:0] mstatus;
    logic [31:0] mie;
    logic [31:0] mip;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;

    // Write enables per register, read-only addresses have none
    assign wr_mstatus  = csr_wr.en && (csr_wr.addr == csr_pkg::addr_mstatus);
    assign wr_mie      = csr_wr.en && (csr_wr.addr == csr_pkg::addr_mie);
    assign wr_mip      = csr_wr.en && (csr_wr.addr == csr_pkg::addr_mip);
    assign wr_mscratch = csr_wr.en && (csr_wr.addr == csr_pkg::addr_mscratch);
    assign wr_mepc     = csr_wr.en && (csr_wr.addr == csr_pkg::addr_mepc);
    assign wr_mcause   = csr_wr.en && (csr_wr.addr == csr_pkg::addr_mcause);
    assign wr_mtval    = csr_wr.en && (csr_wr.addr == csr_pkg::addr_mtval);

    mstatus_reg u_mstatus_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_mstatus),
        .wr_data   (csr_wr.data),
        .trap      (trap_req.valid),
        .mret      (mret),
        .mstatus   (mstatus),
        .priv_mode (priv_mode)
    );

    int_enable_regs u_int_enable_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_mie  (wr_mie),
        .wr_mip  (wr_mip),
        .wr_data (csr_wr.data),
        .mie     (mie),
        .mip     (mip)
    );

    trap_regs #(
        .MEPC_RESET (MEPC_RESET)
    ) u_trap_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_mscratch (wr_mscratch),
        .wr_mepc     (wr_mepc),
        .wr_mcause   (wr_mcause),
        .wr_mtval    (wr_mtval),
        .wr_data     (csr_wr.data),
        .trap_req    (trap_req),
        .priv_mode   (priv_mode),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause),
        .mtval       (mtval)
    );

    // Read mux, unknown addresses read as zero
    always_comb begin
        case (rd_addr)
            csr_pkg::addr_mvendorid,
            csr_pkg::addr_marchid,
            csr_pkg::addr_mimpid,
            csr_pkg::addr_mcounteren: rd_value = '0;
            csr_pkg::addr_mhartid:    rd_value = HART_ID;
            csr_pkg::addr_misa:       rd_value = csr_pkg::misa_value;
            csr_pkg::addr_mtvec:      rd_value = TRAP_VECTOR;
            csr_pkg::addr_mstatus:    rd_value = mstatus;
            csr_pkg::addr_mie:        rd_value = mie;
            csr_pkg::addr_mip:        rd_value = mip;
            csr_pkg::addr_mscratch:   rd_value = mscratch;
            csr_pkg::addr_mepc:       rd_value = mepc;
            csr_pkg::addr_mcause:     rd_value = mcause;
            csr_pkg::addr_mtval:      rd_value = mtval;
            default:                  rd_value = '0;
        endcase
    end

    // Direct mode only, so mtvec is the handler address
    assign trap_vector = TRAP_VECTOR;
    assign mepc_out    = mepc;
    // Not safe for nested traps, mcause keeps only the latest one
    assign is_ecall    = (mcause == csr_pkg::mcause_ecall_m);

    trap_mret_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(trap_req.valid && mret)
    ) else $error("trap and mret in the same cycle");

endmodule

`default_nettype wire

// File: verilog/int_enable_regs.sv
`default_nettype none

module int_enable_regs (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        wr_mie,
    input  wire logic        wr_mip,
    input  wire logic [31:0] wr_data,
    output logic [31:0]      mie,
    output logic [31:0]      mip
);

    logic [31:0] mie_q;
    logic [31:0] mip_q;

    // Software, timer and external bits only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mie_q <= '0;
            mip_q <= '0;
        end else begin
            if (wr_mie) begin
                mie_q <= wr_data & csr_pkg::mie_wmask;
            end
            // Pending bits are plain storage, nothing delivers interrupts
            if (wr_mip) begin
                mip_q <= wr_data & csr_pkg::mip_wmask;
            end
        end
    end

    assign mie = mie_q;
    assign mip = mip_q;

endmodule

`default_nettype wire

// File: verilog/mstatus_reg.sv
`default_nettype none

module mstatus_reg (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           wr_en,
    input  wire logic [31:0]    wr_data,
    input  wire logic           trap,
    input  wire logic           mret,
    output logic [31:0]         mstatus,
    output csr_pkg::priv_t      priv_mode
);

    csr_pkg::mstatus_u status_q;
    csr_pkg::mstatus_u wr_word;
    csr_pkg::priv_t    mode_q;

    // Software write, only the writable fields survive
    always_comb begin
        wr_word.raw = wr_data & csr_pkg::mstatus_wmask;
        // Encoding 2 is reserved for mpp, fall back to U-mode
        if (wr_word.f.mpp == 2'b10) begin
            wr_word.f.mpp = csr_pkg::priv_u;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q.raw <= '0;
            mode_q       <= csr_pkg::priv_m;
        end else if (trap) begin
            // Stack enable and mode, then enter M-mode
            status_q.f.mpie <= status_q.f.mie;
            status_q.f.mie  <= 1'b0;
            status_q.f.mpp  <= mode_q;
            mode_q          <= csr_pkg::priv_m;
        end else if (mret) begin
            mode_q          <= csr_pkg::priv_t'(status_q.f.mpp);
            status_q.f.mie  <= status_q.f.mpie;
            status_q.f.mpie <= 1'b1;
            status_q.f.mpp  <= csr_pkg::priv_u;
        end else if (wr_en) begin
            status_q <= wr_word;
        end
    end

    assign mstatus   = status_q.raw;
    assign priv_mode = mode_q;

    // Covers writes, trap stacking and the reset value together
    mpp_not_reserved: assert property (
        @(posedge clk) disable iff (!rst_n)
        status_q.f.mpp != 2'b10
    ) else $error("mstatus.mpp holds reserved value 2");

endmodule

`default_nettype wire

// File: verilog/trap_regs.sv
`default_nettype none

module trap_regs #(
    parameter logic [31:0] MEPC_RESET = 32'h0001_0000
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                wr_mscratch,
    input  wire logic                wr_mepc,
    input  wire logic                wr_mcause,
    input  wire logic                wr_mtval,
    input  wire logic [31:0]         wr_data,
    input  wire csr_pkg::trap_req_t  trap_req,
    input  wire csr_pkg::priv_t      priv_mode,
    output logic [31:0]              mscratch,
    output logic [31:0]              mepc,
    output logic [31:0]              mcause,
    output logic [31:0]              mtval
);

    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;
    logic [31:0] trap_cause;

    // Ecall code depends on the mode the trap came from
    always_comb begin
        case (trap_req.cause)
            csr_pkg::exc_ecall: begin
                case (priv_mode)
                    csr_pkg::priv_u: trap_cause = csr_pkg::mcause_ecall_u;
                    csr_pkg::priv_s: trap_cause = csr_pkg::mcause_ecall_s;
                    default:         trap_cause = csr_pkg::mcause_ecall_m;
                endcase
            end
            csr_pkg::exc_i_misaligned: trap_cause = csr_pkg::mcause_i_misaligned;
            default:                   trap_cause = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mscratch_q <= '0;
            mepc_q     <= MEPC_RESET;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else begin
            if (wr_mscratch) begin
                mscratch_q <= wr_data;
            end
            // Trap capture beats a CSR write in the same cycle
            if (trap_req.valid) begin
                mepc_q   <= {trap_req.pc[31:2], 2'b00};
                mcause_q <= trap_cause;
                mtval_q  <= trap_req.tval;
            end else begin
                if (wr_mepc) begin
                    mepc_q <= {wr_data[31:2], 2'b00};
                end
                if (wr_mcause) begin
                    mcause_q <= wr_data;
                end
                if (wr_mtval) begin
                    mtval_q <= wr_data;
                end
            end
        end
    end

    assign mscratch = mscratch_q;
    assign mepc     = mepc_q;
    assign mcause   = mcause_q;
    assign mtval    = mtval_q;

    trap_has_cause: assert property (
        @(posedge clk) disable iff (!rst_n)
        trap_req.valid |-> trap_req.cause != csr_pkg::exc_none
    ) else $error("trap strobe without a cause");

endmodule

`default_nettype wire
